//--- rtl/snd_audio_pkg.sv
// Sound datapath definitions
// Sample widths, mixer gains and PCM filter coefficient
`default_nettype none

package snd_audio_pkg;

    localparam int SND_W = 16;  // Mixed output
    localparam int FM_W  = 16;  // Each FM channel
    localparam int PCM_W = 9;   // Signed PCM sample

    // Unsigned gain, 4.4 fixed point
    typedef logic [7:0] gain_t;

    localparam gain_t FM_GAIN = 8'h10;  // 1.0

    // PCM gain per fxlevel, entry 0 is the quietest
    localparam gain_t [3:0] PCM_LEVEL = {8'h0C, 8'h08, 8'h06, 8'h04};

    // Pole position in sixteenths, about 4 kHz at the FM rate
    localparam int POLE_A = 10;

    // Offset binary to two's complement
    localparam int PCM_BIAS = 128;

endpackage

`default_nettype wire

//--- rtl/snd_board.sv
// Arcade sound board top level
// CPU and FM sit outside, their bus and samples arrive as plain ports
`timescale 1ns/1ns
`default_nettype none

module snd_board #(
    parameter int PCM_DEPTH = 4,
    parameter int MIX_SHIFT = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   cen_pcm,    // PCM rate enable
    input  logic                                   fm_sample,  // FM output strobe
    input  logic [1:0]                             fxlevel,
    input  logic                                   enable_fm,
    input  logic                                   enable_psg,
    input  logic [snd_bus_pkg::ADDR_W-1:0]         addr,
    input  logic                                   mreq_n,
    input  logic                                   iorq_n,
    input  logic                                   rd_n,
    input  logic                                   wr_n,
    input  logic [snd_bus_pkg::DATA_W-1:0]         dout,
    output logic [7:0]                             cpu_din,
    output logic                                   cpu_wait,
    output logic                                   int_n,
    output logic                                   nmi_n,
    output logic [snd_bus_pkg::ROM_AW-1:0]         rom_addr,
    output logic                                   rom_cs,
    input  logic [7:0]                             rom_data,
    input  logic                                   rom_ok,
    output logic                                   fm_cs,
    input  logic [7:0]                             fm_dout,
    input  logic signed [snd_audio_pkg::FM_W-1:0]  fm_left,
    input  logic signed [snd_audio_pkg::FM_W-1:0]  fm_right,
    output logic                                   mapper_rd,
    output logic                                   mapper_wr,
    output logic [7:0]                             mapper_din,
    input  logic [7:0]                             mapper_dout,
    input  logic                                   mapper_obf,  // Buffer full
    output logic signed [snd_audio_pkg::SND_W-1:0] snd,
    output logic                                   peak
);
    import snd_audio_pkg::*;

    logic                    pcm_cs;
    logic                    pcm_rst;
    logic                    pcm_mdn;
    logic                    pcm_busyn;
    logic signed [PCM_W-1:0] pcm_raw;  // FIFO output
    logic signed [PCM_W-1:0] pcm_snd;  // After the pole

    snd_bus_if bus ();

    assign bus.addr   = addr;
    assign bus.mreq_n = mreq_n;
    assign bus.iorq_n = iorq_n;
    assign bus.rd_n   = rd_n;
    assign bus.wr_n   = wr_n;
    assign bus.dout   = dout;

    assign int_n = ~mapper_obf;  // Mapper has a command waiting

    snd_bus_decode u_decode (
        .clk(clk), .rst(rst), .bus(bus.decoder),
        .rom_data(rom_data), .rom_ok(rom_ok),
        .fm_dout(fm_dout), .mapper_dout(mapper_dout), .pcm_busyn(pcm_busyn),
        .rom_addr(rom_addr), .rom_cs(rom_cs), .cpu_wait(cpu_wait), .cpu_din(cpu_din),
        .fm_cs(fm_cs), .pcm_cs(pcm_cs), .mapper_rd(mapper_rd), .mapper_wr(mapper_wr),
        .mapper_din(mapper_din), .pcm_rst(pcm_rst), .pcm_mdn(pcm_mdn)
    );

    snd_pcm_fifo #(.PCM_DEPTH(PCM_DEPTH)) u_pcm (
        .clk(clk), .rst(rst), .bus(bus.pcm),
        .pcm_cs(pcm_cs), .pcm_rst(pcm_rst), .pcm_mdn(pcm_mdn), .cen_pcm(cen_pcm),
        .busyn(pcm_busyn), .drq_n(nmi_n), .pcm_raw(pcm_raw)
    );

    // Filter runs at the FM sample rate
    snd_pole u_pole (
        .clk(clk), .rst(rst), .sample(fm_sample), .sin(pcm_raw), .sout(pcm_snd)
    );

    snd_mixer #(.MIX_SHIFT(MIX_SHIFT)) u_mixer (
        .clk(clk), .rst(rst), .fxlevel(fxlevel),
        .enable_fm(enable_fm), .enable_psg(enable_psg),
        .fm_left(fm_left), .fm_right(fm_right), .pcm(pcm_snd),
        .snd(snd), .peak(peak)
    );

endmodule

`default_nettype wire

//--- rtl/snd_bus_decode.sv
// Sound CPU address decoder
// Chip selects, ROM banking, control latch, ROM wait and read data mux
`timescale 1ns/1ns
`default_nettype none

module snd_bus_decode (
    input  logic                           clk,
    input  logic                           rst,
    snd_bus_if.decoder                     bus,
    input  logic [7:0]                     rom_data,
    input  logic                           rom_ok,
    input  logic [7:0]                     fm_dout,
    input  logic [7:0]                     mapper_dout,
    input  logic                           pcm_busyn,
    output logic [snd_bus_pkg::ROM_AW-1:0] rom_addr,
    output logic                           rom_cs,
    output logic                           cpu_wait,
    output logic [7:0]                     cpu_din,
    output logic                           fm_cs,
    output logic                           pcm_cs,
    output logic                           mapper_rd,
    output logic                           mapper_wr,
    output logic [7:0]                     mapper_din,
    output logic                           pcm_rst,
    output logic                           pcm_mdn
);
    import snd_bus_pkg::*;

    logic [3:0] nibble;      // A15..A12
    io_port_e   port;
    logic       bank_cs;
    logic       misc_cs;
    logic       mapper_cs;
    logic       rom_ok2;     // rom_ok one clock ago
    logic       rom_good;
    logic [5:0] rom_msb;     // Bank bits from the control latch

    assign nibble  = bus.addr[15:12];
    assign port    = io_port_e'(bus.addr[7:6]);
    assign bank_cs = !bus.mreq_n && (nibble >= BANK_LO) && (nibble < BANK_HI);

    // Port selects
    always_comb begin
        fm_cs     = 1'b0;
        misc_cs   = 1'b0;
        pcm_cs    = 1'b0;
        mapper_cs = 1'b0;
        if (!bus.iorq_n) begin
            case (port)
                PORT_FM:     fm_cs     = 1'b1;
                PORT_MISC:   misc_cs   = 1'b1;
                PORT_PCM:    pcm_cs    = 1'b1;
                PORT_MAPPER: mapper_cs = 1'b1;
            endcase
        end else begin
            // Memory mapped mapper at 0xE800
            mapper_cs = !bus.mreq_n && (nibble == MAPPER_MEM_NIBBLE) && bus.addr[11];
        end
    end

    assign mapper_rd  = mapper_cs && !bus.rd_n;
    assign mapper_wr  = mapper_cs && !bus.wr_n;
    assign mapper_din = bus.dout;

    // ROM address, banked window replaces A15 and up
    always_comb begin
        rom_addr       = '0;
        rom_addr[14:0] = bus.addr[14:0];
        if (bank_cs) begin
            rom_addr[15:14] = rom_msb[1:0];
            // Highest set bit picks the ROM chip
            if (rom_msb[5]) begin
                rom_addr[17:16] = 2'd3;
            end else if (rom_msb[4]) begin
                rom_addr[17:16] = 2'd2;
            end else if (rom_msb[3]) begin
                rom_addr[17:16] = 2'd1;
            end else begin
                rom_addr[17:16] = 2'd0;  // A8 or no chip bit
            end
        end
    end

    // ROM request and ready history
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_cs  <= 1'b0;
            rom_ok2 <= 1'b0;
        end else begin
            rom_cs  <= (!bus.mreq_n && !bus.addr[15]) || bank_cs;  // Fixed + banked
            rom_ok2 <= rom_ok;
        end
    end

    // Data counts only after two ready clocks
    assign rom_good = rom_ok && rom_ok2;
    assign cpu_wait = rom_cs && !rom_good;  // Hold the CPU cycle

    // Registered read mux
    always_ff @(posedge clk) begin
        if (rom_cs) begin
            cpu_din <= rom_data;
        end else if (fm_cs) begin
            cpu_din <= fm_dout;
        end else if (pcm_cs) begin
            cpu_din <= {pcm_busyn, 7'd0};  // Status, busy in bit 7
        end else if (mapper_cs) begin
            cpu_din <= mapper_dout;
        end else begin
            cpu_din <= READ_IDLE;
        end
    end

    // Control latch on MISC writes
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            rom_msb <= '0;
            pcm_rst <= 1'b1;  // PCM held in reset
            pcm_mdn <= 1'b1;  // Stand alone mode
        end else if (misc_cs && !bus.wr_n) begin
            rom_msb <= bus.dout[5:0];
            pcm_rst <= ~bus.dout[6];
            pcm_mdn <= ~bus.dout[7];
        end
    end

endmodule

`default_nettype wire

//--- rtl/snd_bus_if.sv
// Sound CPU bus as seen by the peripherals
`timescale 1ns/1ns
`default_nettype none

interface snd_bus_if;
    import snd_bus_pkg::*;

    logic [ADDR_W-1:0] addr;    // CPU address
    logic              mreq_n;  // Memory request
    logic              iorq_n;  // I/O request
    logic              rd_n;
    logic              wr_n;
    logic [DATA_W-1:0] dout;    // CPU write data

    // Decoder watches the whole cycle
    modport decoder (
        input addr, mreq_n, iorq_n, rd_n, wr_n, dout
    );

    // PCM FIFO only needs the write strobe and data
    modport pcm (
        input wr_n, dout
    );

endinterface

`default_nettype wire

//--- rtl/snd_bus_pkg.sv
// Sound CPU bus definitions
// Address map, I/O port groups and bank window limits
`default_nettype none

package snd_bus_pkg;

    localparam int ADDR_W = 16;  // CPU address bus
    localparam int DATA_W = 8;   // CPU data bus
    localparam int ROM_AW = 19;  // External ROM port

    // I/O groups picked by A7..A6
    typedef enum logic [1:0] {
        PORT_FM     = 2'd0,
        PORT_MISC   = 2'd1,
        PORT_PCM    = 2'd2,
        PORT_MAPPER = 2'd3
    } io_port_e;

    // Banked window on A15..A12, 0x8000 up to but not including 0xE000
    localparam logic [3:0] BANK_LO = 4'd8;
    localparam logic [3:0] BANK_HI = 4'd14;

    // Mapper mirror in memory space at 0xE800 (A11 set)
    localparam logic [3:0] MAPPER_MEM_NIBBLE = 4'd14;

    // Open bus value
    localparam logic [7:0] READ_IDLE = 8'hFF;

endpackage

`default_nettype wire

//--- rtl/snd_mixer.sv
// Three channel gain mixer, FM left and right plus PCM
// 4.4 gains, saturation to the output width and peak flag
`timescale 1ns/1ns
`default_nettype none

module snd_mixer #(
    parameter int MIX_SHIFT = 4
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [1:0]                             fxlevel,
    input  logic                                   enable_fm,
    input  logic                                   enable_psg,
    input  logic signed [snd_audio_pkg::FM_W-1:0]  fm_left,
    input  logic signed [snd_audio_pkg::FM_W-1:0]  fm_right,
    input  logic signed [snd_audio_pkg::PCM_W-1:0] pcm,
    output logic signed [snd_audio_pkg::SND_W-1:0] snd,
    output logic                                   peak
);
    import snd_audio_pkg::*;

    localparam int SUM_W = FM_W + 11;  // Room for three weighted channels
    localparam logic signed [SUM_W-1:0] SAT_MAX = SUM_W'(2**(SND_W-1) - 1);
    localparam logic signed [SUM_W-1:0] SAT_MIN = -SAT_MAX - 1;

    gain_t                   fm_gain;
    gain_t                   pcm_gain;
    logic signed [FM_W+8:0]  w_left;
    logic signed [FM_W+8:0]  w_right;
    logic signed [PCM_W+8:0] w_pcm;
    logic signed [SUM_W-1:0] sum;
    logic signed [SUM_W-1:0] scaled;

    // Gains are unsigned, so extend with a zero before the signed multiply
    assign w_left  = fm_left  * $signed({1'b0, fm_gain});
    assign w_right = fm_right * $signed({1'b0, fm_gain});
    assign w_pcm   = pcm      * $signed({1'b0, pcm_gain});

    assign sum    = w_left + w_right + w_pcm;
    assign scaled = sum >>> MIX_SHIFT;  // Back from 4.4

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            fm_gain  <= '0;
            pcm_gain <= '0;
            snd      <= '0;
            peak     <= 1'b0;
        end else begin
            fm_gain  <= enable_fm  ? FM_GAIN            : '0;
            pcm_gain <= enable_psg ? PCM_LEVEL[fxlevel] : '0;
            // Clip to output range
            if (scaled > SAT_MAX) begin
                snd  <= SND_W'(SAT_MAX);
                peak <= 1'b1;
            end else if (scaled < SAT_MIN) begin
                snd  <= SND_W'(SAT_MIN);
                peak <= 1'b1;
            end else begin
                snd  <= scaled[SND_W-1:0];
                peak <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/snd_pcm_fifo.sv
// PCM sample FIFO in slave mode
// CPU pushes bytes, cen_pcm pops them into a signed sample
`timescale 1ns/1ns
`default_nettype none

module snd_pcm_fifo #(
    parameter int PCM_DEPTH = 4
) (
    input  logic                                  clk,
    input  logic                                  rst,
    snd_bus_if.pcm                                bus,
    input  logic                                  pcm_cs,
    input  logic                                  pcm_rst,
    input  logic                                  pcm_mdn,
    input  logic                                  cen_pcm,
    output logic                                  busyn,
    output logic                                  drq_n,
    output logic signed [snd_audio_pkg::PCM_W-1:0] pcm_raw
);
    import snd_audio_pkg::*;

    localparam int AW = $clog2(PCM_DEPTH);

    logic [7:0]    mem [PCM_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;    // Entries held
    logic          wr_n_q;   // Strobe edge detect
    logic          full;
    logic          empty;
    logic          push;
    logic          pop;

    assign full  = (count == (AW+1)'(PCM_DEPTH));
    assign empty = (count == '0);

    // One push per falling wr_n, dropped when full
    assign push = pcm_cs && wr_n_q && !bus.wr_n && !full && !pcm_rst;
    assign pop  = cen_pcm && !empty && !pcm_rst;

    assign busyn = !full;
    assign drq_n = pcm_rst || pcm_mdn || full;  // Ask for data in slave mode

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_n_q  <= 1'b1;
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            pcm_raw <= '0;
        end else begin
            wr_n_q <= bus.wr_n;
            if (pcm_rst) begin
                wr_ptr  <= '0;
                rd_ptr  <= '0;
                count   <= '0;
                pcm_raw <= '0;
            end else begin
                if (push) wr_ptr <= wr_ptr + 1'b1;
                if (pop) begin
                    rd_ptr  <= rd_ptr + 1'b1;
                    pcm_raw <= PCM_W'($signed({1'b0, mem[rd_ptr]}) - PCM_BIAS);
                end
                case ({push, pop})
                    2'b10:   count <= count + 1'b1;
                    2'b01:   count <= count - 1'b1;
                    default: count <= count;  // Idle or both
                endcase
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= bus.dout;
    end

endmodule

`default_nettype wire

//--- rtl/snd_pole.sv
// One-pole low-pass on the PCM sample
// y += (x - y) * (16 - a) / 16 on each sample strobe
`timescale 1ns/1ns
`default_nettype none

module snd_pole (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   sample,
    input  logic signed [snd_audio_pkg::PCM_W-1:0] sin,
    output logic signed [snd_audio_pkg::PCM_W-1:0] sout
);
    import snd_audio_pkg::*;

    localparam int FRAC = 4;             // Extra fraction bits
    localparam int AW   = PCM_W + FRAC;  // Accumulator width
    localparam logic signed [5:0] COEF = 6'(16 - POLE_A);

    logic signed [AW-1:0] acc;    // Filter state
    logic signed [AW-1:0] sin_x;  // Input at accumulator scale
    logic signed [AW:0]   diff;
    logic signed [AW+6:0] prod;
    logic signed [AW+6:0] step;

    assign sin_x = {sin, {FRAC{1'b0}}};
    assign diff  = sin_x - acc;
    assign prod  = diff * COEF;
    assign step  = prod >>> 4;  // Sixteenths

    // Step never overshoots the input so it fits the accumulator
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc <= '0;
        end else if (sample) begin
            acc <= acc + $signed(step[AW-1:0]);
        end
    end

    assign sout = acc[AW-1:FRAC];  // Drop the fraction

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Compile and run the sound board testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_snd_board -Mdir obj_dir -o sim_snd_board
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_snd_board > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
exit 0

//--- sim.f
rtl/snd_bus_pkg.sv
rtl/snd_audio_pkg.sv
rtl/snd_bus_if.sv
rtl/snd_bus_decode.sv
rtl/snd_pcm_fifo.sv
rtl/snd_pole.sv
rtl/snd_mixer.sv
rtl/snd_board.sv
test/tb_snd_board.sv

//--- test/tb_snd_board.sv
// Testbench for the arcade sound board
// Table rows drive bus cycles, option changes and sample strobes, then check one signal
`timescale 1ns/1ns
`default_nettype none

module tb_snd_board;
    import snd_audio_pkg::*;

    localparam int OP_IOW  = 0;
    localparam int OP_MEMW = 1;
    localparam int OP_IOR  = 2;
    localparam int OP_MEMR = 3;
    localparam int OP_FM   = 4;
    localparam int OP_OPT  = 5;
    localparam int OP_PCM  = 6;
    localparam int OP_FLT  = 7;

    logic                    clk = 1'b0;
    logic                    rst;
    logic                    cen_pcm;
    logic                    fm_sample;
    logic                    enable_fm;
    logic                    enable_psg;
    logic [1:0]              fxlevel;
    logic [15:0]             addr;
    logic                    mreq_n;
    logic                    iorq_n;
    logic                    rd_n;
    logic                    wr_n;
    logic [7:0]              dout;
    logic                    rom_ok;
    logic [7:0]              rom_data;
    logic [7:0]              fm_dout;
    logic [7:0]              mapper_dout;
    logic                    mapper_obf;
    logic signed [FM_W-1:0]  fm_left;
    logic signed [FM_W-1:0]  fm_right;
    logic [7:0]              cpu_din;
    logic                    cpu_wait;
    logic                    int_n;
    logic                    nmi_n;
    logic [18:0]             rom_addr;
    logic                    rom_cs;
    logic                    fm_cs;
    logic                    mapper_rd;
    logic                    mapper_wr;
    logic [7:0]              mapper_din;
    logic signed [SND_W-1:0] snd;
    logic                    peak;

    // Stimulus table, one entry per row in each queue
    int          op_q[$];
    int          dly_q[$];
    logic [15:0] a_q[$];
    logic [15:0] d_q[$];
    logic [31:0] exp_q[$];
    string       sig_q[$];

    int         errors = 0;
    int         failed = 0;
    int         cycles = 0;
    int         limit  = 0;
    int         seed   = 33;
    logic       row_bad;
    logic [7:0] rom_key;

    snd_board #(.PCM_DEPTH(4), .MIX_SHIFT(4)) dut (.*);

    always #50 clk = ~clk;

    // ROM model whose byte depends on every address bit
    function automatic logic [7:0] rom_byte(input logic [18:0] a, input logic [7:0] k);
        return a[7:0] ^ a[15:8] ^ {5'd0, a[18:16]} ^ k;
    endfunction
    assign rom_data = rom_byte(rom_addr, rom_key);

    // Watchdog sized from the table
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: run did not end within %0d cycles", limit);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] pick(input string name);
        case (name)
            "rom_addr":               return {13'd0, rom_addr};
            "cpu_din":                return {24'd0, cpu_din};
            "fm_cs":                  return {31'd0, fm_cs};
            "mapper_rd":              return {31'd0, mapper_rd};
            "{mapper_wr,mapper_din}": return {23'd0, mapper_wr, mapper_din};
            "int_n":                  return {31'd0, int_n};
            "nmi_n":                  return {31'd0, nmi_n};
            "snd":                    return {16'd0, snd};
            "{peak,snd}":             return {15'd0, peak, snd};
            default:                  return 'x;  // Never matches
        endcase
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) begin
            $display("Mismatch at %0t ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            errors++;
            row_bad = 1'b1;
        end
    endtask

    task automatic add(input int op, input logic [15:0] a, input logic [15:0] d,
                       input int dly, input logic [31:0] exp, input string sig);
        op_q.push_back(op);
        a_q.push_back(a);
        d_q.push_back(d);
        dly_q.push_back(dly);
        exp_q.push_back(exp);
        sig_q.push_back(sig);
    endtask

    // Inputs change just after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic bus_write(input logic mem, input logic [15:0] a, input logic [7:0] d);
        addr = a;
        dout = d;
        wr_n = 1'b0;
        if (mem) mreq_n = 1'b0;
        else iorq_n = 1'b0;
        next_cycle();  // Strobe seen on this edge
    endtask

    // Holds the cycle while cpu_wait is high, raises rom_ok after dly wait clocks
    task automatic bus_read(input logic mem, input logic [15:0] a, input int dly,
                            output int waits);
        logic done;
        waits = 0;
        done  = 1'b0;
        addr  = a;
        rd_n  = 1'b0;
        if (mem) mreq_n = 1'b0;
        else iorq_n = 1'b0;
        while (!done) begin
            next_cycle();
            if (!cpu_wait) begin
                done = 1'b1;
            end else begin
                waits++;
                if (waits == dly) begin
                    rom_ok = 1'b1;
                    #1;
                    // A single ready clock must not release the CPU
                    compare("cpu_wait", 32'h1, {31'd0, cpu_wait});
                end
            end
        end
    endtask

    task automatic pulse(input logic flt, input int n);
        repeat (n) begin
            if (flt) fm_sample = 1'b1;
            else cen_pcm = 1'b1;
            next_cycle();
            fm_sample = 1'b0;
            cen_pcm   = 1'b0;
        end
        next_cycle();  // Mixer register
    endtask

    task automatic bus_idle();
        mreq_n = 1'b1;
        iorq_n = 1'b1;
        rd_n   = 1'b1;
        wr_n   = 1'b1;
        rom_ok = 1'b0;
        next_cycle();  // Lets rom_cs drop before the next row
    endtask

    function automatic string op_name(input int op);
        case (op)
            OP_IOW:  return "io write";
            OP_MEMW: return "mem write";
            OP_IOR:  return "io read";
            OP_MEMR: return "mem read";
            OP_FM:   return "fm inputs";
            OP_OPT:  return "options";
            OP_PCM:  return "pcm tick";
            default: return "filter tick";
        endcase
    endfunction

    initial begin
        int   waits;
        logic rom_hit;
        rst         = 1'b1;
        cen_pcm     = 1'b0;
        fm_sample   = 1'b0;
        fxlevel     = 2'd0;
        enable_fm   = 1'b0;
        enable_psg  = 1'b0;
        addr        = 16'h0000;
        dout        = 8'h00;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        rom_ok      = 1'b0;
        fm_dout     = 8'h3E;
        mapper_dout = 8'hA5;
        mapper_obf  = 1'b0;
        fm_left     = '0;
        fm_right    = '0;
        rom_key     = 8'($random(seed));
        // Latch 0x12 gives chip 2 and page 2, 0x2B chip 3 page 3, 0x01 page 1
        add(OP_IOW,  16'h0040, 16'h0012, 0, 32'h1,     "nmi_n");
        add(OP_MEMR, 16'h9234, 16'h0000, 1, 32'h29234, "rom_addr");
        add(OP_IOW,  16'h0040, 16'h002B, 0, 32'h1,     "nmi_n");
        add(OP_MEMR, 16'hC001, 16'h0000, 2, 32'h3C001, "rom_addr");
        add(OP_IOW,  16'h0040, 16'h0001, 0, 32'h1,     "nmi_n");
        add(OP_MEMR, 16'hA0FF, 16'h0000, 1, 32'h060FF, "rom_addr");
        add(OP_MEMR, 16'h4567, 16'h0000, 1, 32'h04567, "rom_addr");  // Fixed area
        add(OP_MEMR, 16'h1234, 16'h0000, 4, 32'h01234, "rom_addr");  // Long wait
        add(OP_MEMR, 16'hDFFF, 16'h0000, 3, 32'h05FFF, "rom_addr");
        // Port selects
        add(OP_IOW,  16'h0000, 16'h005A, 0, 32'h1,     "fm_cs");
        add(OP_IOW,  16'h00C0, 16'h003C, 0, 32'h13C,   "{mapper_wr,mapper_din}");
        add(OP_MEMW, 16'hE800, 16'h0096, 0, 32'h196,   "{mapper_wr,mapper_din}");
        add(OP_IOR,  16'h00C0, 16'h0000, 0, 32'h1,     "mapper_rd");
        add(OP_IOR,  16'h00C0, 16'h0000, 0, 32'hA5,    "cpu_din");
        add(OP_IOR,  16'h0000, 16'h0000, 0, 32'h3E,    "cpu_din");
        add(OP_MEMR, 16'hE000, 16'h0000, 0, 32'hFF,    "cpu_din");   // Nothing selected
        add(OP_OPT,  16'h0000, 16'h0010, 1, 32'h0,     "int_n");
        add(OP_OPT,  16'h0000, 16'h0000, 1, 32'h1,     "int_n");
        // Slave mode PCM FIFO filled past its depth
        add(OP_IOR,  16'h0080, 16'h0000, 0, 32'h80,    "cpu_din");
        add(OP_IOW,  16'h0040, 16'h00C0, 0, 32'h0,     "nmi_n");
        add(OP_IOW,  16'h0080, 16'h00C0, 0, 32'h0,     "nmi_n");     // +64
        add(OP_IOW,  16'h0080, 16'h0090, 0, 32'h0,     "nmi_n");     // +16
        add(OP_IOW,  16'h0080, 16'h0070, 0, 32'h0,     "nmi_n");     // -16
        add(OP_IOW,  16'h0080, 16'h0080, 0, 32'h1,     "nmi_n");     // Zero fills the FIFO
        add(OP_IOR,  16'h0080, 16'h0000, 0, 32'h00,    "cpu_din");
        add(OP_IOW,  16'h0080, 16'h00FF, 0, 32'h1,     "nmi_n");     // Dropped
        add(OP_PCM,  16'h0000, 16'h0000, 1, 32'h0,     "nmi_n");
        add(OP_IOR,  16'h0080, 16'h0000, 0, 32'h80,    "cpu_din");
        // Filter 64 over three ticks gives 24, 39, 48, then gain per fxlevel
        add(OP_OPT,  16'h0000, 16'h000C, 2, 32'h0,     "snd");
        add(OP_FLT,  16'h0000, 16'h0000, 3, 32'h0C,    "snd");       // 48 * 4 / 16
        add(OP_OPT,  16'h0000, 16'h000D, 2, 32'h12,    "snd");
        add(OP_OPT,  16'h0000, 16'h000E, 2, 32'h18,    "snd");
        add(OP_OPT,  16'h0000, 16'h000F, 2, 32'h24,    "snd");
        // Drain to zero with one extra tick that must not pop the dropped byte
        add(OP_PCM,  16'h0000, 16'h0000, 4, 32'h0,     "nmi_n");
        add(OP_FLT,  16'h0000, 16'h0000, 1, 32'h16,    "snd");       // 30 * 12 / 16
        add(OP_OPT,  16'h0000, 16'h0004, 2, 32'h0,     "snd");       // PSG off
        // Saturation at unity FM gain
        add(OP_FM,   16'h7000, 16'h7000, 1, 32'h17FFF, "{peak,snd}");
        add(OP_FM,   16'h8000, 16'h8000, 1, 32'h18000, "{peak,snd}");
        add(OP_FM,   16'h2000, 16'h1000, 1, 32'h03000, "{peak,snd}");
        add(OP_FM,   16'h7000, 16'h7000, 1, 32'h17FFF, "{peak,snd}");
        add(OP_OPT,  16'h0000, 16'h0000, 2, 32'h0,     "{peak,snd}");
        limit = op_q.size() * 20;

        repeat (4) @(posedge clk);
        #5 rst = 1'b0;
        row_bad = 1'b0;
        compare("rom_cs", 32'h0, {31'd0, rom_cs});
        compare("cpu_wait", 32'h0, {31'd0, cpu_wait});
        compare("{mapper_rd,mapper_wr}", 32'h0, {30'd0, mapper_rd, mapper_wr});
        compare("nmi_n", 32'h1, {31'd0, nmi_n});
        compare("{peak,snd}", 32'h0, {15'd0, peak, snd});
        $display("test reset: %s", row_bad ? "fail" : "pass");
        if (row_bad) failed++;

        for (int i = 0; i < op_q.size(); i++) begin
            row_bad = 1'b0;
            case (op_q[i])
                OP_IOW:  bus_write(1'b0, a_q[i], d_q[i][7:0]);
                OP_MEMW: bus_write(1'b1, a_q[i], d_q[i][7:0]);
                OP_IOR:  bus_read(1'b0, a_q[i], 0, waits);
                OP_MEMR: begin
                    rom_hit = a_q[i] < 16'hE000;  // Fixed area and banked window
                    bus_read(1'b1, a_q[i], dly_q[i], waits);
                    compare("cpu_wait clocks", 32'(dly_q[i]), 32'(waits));
                    compare("rom_cs", {31'd0, rom_hit}, {31'd0, rom_cs});
                    if (rom_hit)
                        compare("cpu_din", {24'd0, rom_byte(exp_q[i][18:0], rom_key)},
                                {24'd0, cpu_din});
                end
                OP_FM: begin
                    fm_left  = a_q[i];
                    fm_right = d_q[i];
                    repeat (dly_q[i]) next_cycle();
                end
                OP_OPT: begin
                    {mapper_obf, enable_psg, enable_fm, fxlevel} = d_q[i][4:0];
                    repeat (dly_q[i]) next_cycle();
                end
                OP_PCM:  pulse(1'b0, dly_q[i]);
                default: pulse(1'b1, dly_q[i]);
            endcase
            compare(sig_q[i], exp_q[i], pick(sig_q[i]));
            bus_idle();
            if (row_bad) failed++;
            $display("test %0d %s, %s: %s", i, op_name(op_q[i]), sig_q[i],
                     row_bad ? "fail" : "pass");
        end

        $display("%0d tests, %0d failed, %0d errors", op_q.size() + 1, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire
